// ==== bench/tl_tb.sv ====
`include "tl_consts.svh"

module tl_tb;

    localparam int CLK_HALF        = 10;
    localparam int RESET_CYCLES    = 4;
    localparam int STALL_LIMIT     = 20;   // MMU answers within 5 cycles
    // Six short tests take well under 100 cycles
    localparam int WATCHDOG_CYCLES = 400;

    logic                      clk_i;
    logic                      rst_n_i;
    logic [`TL_WORD_W-1:0]     alu_res_i;
    logic                      rf_we_i;
    logic [`TL_REG_ADDR_W-1:0] rf_waddr_i;
    logic [`TL_WORD_W-1:0]     st_data_i;
    logic                      mem_rd_i;
    logic                      mem_wr_i;
    tl_pkg::mem_size_e         mem_size_i;
    logic                      sign_ext_i;
    logic                      tkbr_i;
    logic [`TL_WORD_W-1:0]     new_pc_i;
    logic [`TL_WORD_W-1:0]     alu_res_o;
    logic                      rf_we_o;
    logic [`TL_REG_ADDR_W-1:0] rf_waddr_o;
    logic                      mem_rd_o;
    logic                      mem_wr_o;
    tl_pkg::mem_size_e         mem_size_o;
    logic                      sign_ext_o;
    logic                      tkbr_o;
    logic [`TL_WORD_W-1:0]     new_pc_o;
    logic [`TL_INDEX_W-1:0]    addr_index_o;
    logic                      sb_hit_o;
    logic [`TL_WORD_W-1:0]     sb_load_data_o;
    logic                      sb_flush_o;
    logic [`TL_WORD_W-1:0]     sb_addr_o;
    logic [`TL_WORD_W-1:0]     sb_flush_data_o;
    tl_pkg::mem_size_e         sb_flush_size_o;
    logic                      mmu_data_rdy_i;
    logic [`TL_WORD_W-1:0]     mmu_fill_addr_i;
    logic [`TL_INDEX_W-1:0]    mmu_lru_index_i;
    logic                      mmu_miss_o;
    logic [`TL_WORD_W-1:0]     mmu_addr_o;
    logic                      hazard_o;

    logic [15:0] lfsr_q;
    int          fill_count;
    logic [`TL_INDEX_W-1:0] fill_slot [logic [`TL_TAG_W-1:0]];  // Slot per filled line

    tl_stage uut (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .alu_res_i (alu_res_i), .rf_we_i (rf_we_i), .rf_waddr_i (rf_waddr_i),
        .st_data_i (st_data_i), .mem_rd_i (mem_rd_i), .mem_wr_i (mem_wr_i),
        .mem_size_i (mem_size_i), .sign_ext_i (sign_ext_i), .tkbr_i (tkbr_i),
        .new_pc_i (new_pc_i),
        .alu_res_o (alu_res_o), .rf_we_o (rf_we_o), .rf_waddr_o (rf_waddr_o),
        .mem_rd_o (mem_rd_o), .mem_wr_o (mem_wr_o), .mem_size_o (mem_size_o),
        .sign_ext_o (sign_ext_o), .tkbr_o (tkbr_o), .new_pc_o (new_pc_o),
        .addr_index_o (addr_index_o), .sb_hit_o (sb_hit_o),
        .sb_load_data_o (sb_load_data_o), .sb_flush_o (sb_flush_o),
        .sb_addr_o (sb_addr_o), .sb_flush_data_o (sb_flush_data_o),
        .sb_flush_size_o (sb_flush_size_o),
        .mmu_data_rdy_i (mmu_data_rdy_i), .mmu_fill_addr_i (mmu_fill_addr_i),
        .mmu_lru_index_i (mmu_lru_index_i), .mmu_miss_o (mmu_miss_o),
        .mmu_addr_o (mmu_addr_o), .hazard_o (hazard_o)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};  // One step per bit
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("** FAIL **");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run aborted");
    endtask

    task automatic step_clock;
        @(posedge clk_i);
        #1;
    endtask

    task automatic drive_idle;
        mem_rd_i   = 1'b0;
        mem_wr_i   = 1'b0;
        rf_we_i    = 1'b0;
        tkbr_i     = 1'b0;
        sign_ext_i = 1'b0;
        mem_size_i = tl_pkg::MEM_WORD;
    endtask

    task automatic drive_mem(input logic rd, input logic [31:0] addr,
                             input logic [31:0] data, input tl_pkg::mem_size_e size);
        drive_idle();
        mem_rd_i   = rd;
        mem_wr_i   = ~rd;
        rf_we_i    = rd;   // Loads write back
        rf_waddr_i = 5'd7;
        alu_res_i  = addr;
        st_data_i  = data;
        mem_size_i = size;
    endtask

    // Store that the buffer can take without a stall
    task automatic issue_store(input logic [31:0] addr, input logic [31:0] data,
                               input tl_pkg::mem_size_e size);
        drive_mem(1'b0, addr, data, size);
        @(negedge clk_i);
        assert (!hazard_o) else report_error("hazard_o high for an accepted store");
        step_clock();
        assert (!mem_wr_o && !sb_flush_o) else report_error("store reached memory directly");
    endtask

    task automatic drain_and_check(input logic [31:0] addr, input logic [31:0] data,
                                   input tl_pkg::mem_size_e size);
        drive_idle();
        step_clock();
        assert (sb_flush_o && mem_wr_o && sb_addr_o == addr && sb_flush_data_o == data &&
                sb_flush_size_o == size)
        else report_error($sformatf("drain got addr %h data %h, expected %h %h",
                                    sb_addr_o, sb_flush_data_o, addr, data));
    endtask

    task automatic expect_empty;
        drive_idle();
        step_clock();
        assert (!sb_flush_o && !mem_wr_o) else report_error("drain from an empty buffer");
    endtask

    task automatic test_reset;
        assert (!hazard_o && !mmu_miss_o && !rf_we_o && !mem_rd_o && !mem_wr_o &&
                !sb_hit_o && !sb_flush_o && !tkbr_o && !sign_ext_o &&
                mem_size_o == tl_pkg::MEM_WORD)
        else report_error("outputs not at their reset values");
    endtask

    task automatic test_pass_through;
        logic [31:0] res;
        logic [31:0] pc;
        logic [31:0] r;
        res = rand_bits(32);
        pc  = rand_bits(32) & ~32'h3;
        r   = rand_bits(`TL_REG_ADDR_W);
        drive_idle();
        alu_res_i  = res;
        rf_we_i    = 1'b1;
        rf_waddr_i = r[`TL_REG_ADDR_W-1:0];
        tkbr_i     = 1'b1;
        sign_ext_i = 1'b1;
        mem_size_i = tl_pkg::MEM_BYTE;
        new_pc_i   = pc;
        @(negedge clk_i);
        assert (!hazard_o) else report_error("hazard_o high for a non-memory operation");
        step_clock();
        assert (alu_res_o == res && rf_we_o && rf_waddr_o == r[`TL_REG_ADDR_W-1:0] &&
                tkbr_o && new_pc_o == pc && !mem_rd_o && !mem_wr_o)
        else report_error($sformatf("pass-through gave alu %h pc %h", alu_res_o, new_pc_o));
        assert (sign_ext_o && mem_size_o == tl_pkg::MEM_BYTE)
        else report_error($sformatf("pass-through gave sign_ext %b size %0d",
                                    sign_ext_o, mem_size_o));
        drive_idle();
    endtask

    task automatic test_load_miss;
        logic [31:0]          addr;
        logic [`TL_TAG_W-1:0] line;
        int                   base_fills;
        int                   cycles;
        addr       = rand_bits(32) & ~32'h3;
        line       = addr[`TL_WORD_W-1:`TL_OFFSET_W];
        base_fills = fill_count;
        cycles     = 0;
        drive_mem(1'b1, addr, '0, tl_pkg::MEM_WORD);
        @(negedge clk_i);
        assert (hazard_o && mmu_miss_o) else report_error("load miss did not stall");
        assert (mmu_addr_o == {line, {`TL_OFFSET_W{1'b0}}})
        else report_error($sformatf("mmu_addr_o %h for load %h", mmu_addr_o, addr));
        while (hazard_o) begin
            @(negedge clk_i);
            cycles++;
            assert (!rf_we_o && !mem_rd_o) else report_error("stalled load left the stage");
            if (cycles > STALL_LIMIT) abort_run("hazard_o never fell after the load miss");
        end
        assert (fill_count == base_fills + 1) else report_error("stall ended without a fill");
        step_clock();
        assert (mem_rd_o && rf_we_o && !sb_hit_o && addr_index_o == fill_slot[line])
        else report_error($sformatf("refilled load gave index %0d", addr_index_o));
        // Same line, other word
        drive_mem(1'b1, addr ^ 32'h8, '0, tl_pkg::MEM_WORD);
        @(negedge clk_i);
        assert (!hazard_o && !mmu_miss_o) else report_error("second load to the line stalled");
        step_clock();
        assert (mem_rd_o && addr_index_o == fill_slot[line])
        else report_error($sformatf("second load gave index %0d", addr_index_o));
        drive_idle();
    endtask

    task automatic test_forwarding;
        logic [31:0] addr;
        logic [31:0] d1;
        logic [31:0] d2;
        addr = rand_bits(32) & ~32'h3;
        d1   = rand_bits(32);
        d2   = rand_bits(32);
        issue_store(addr, d1, tl_pkg::MEM_WORD);
        issue_store(addr, d2, tl_pkg::MEM_WORD);  // Merges into the first
        drive_mem(1'b1, addr, '0, tl_pkg::MEM_WORD);
        @(negedge clk_i);
        assert (!hazard_o && !mmu_miss_o) else report_error("forwarded load stalled");
        step_clock();
        assert (sb_hit_o && !mem_rd_o && sb_load_data_o == d2)
        else report_error($sformatf("forwarded %h, expected %h", sb_load_data_o, d2));
        drain_and_check(addr, d2, tl_pkg::MEM_WORD);
        expect_empty();
    endtask

    task automatic test_drain_order;
        logic [31:0] a1;
        logic [31:0] d1;
        logic [31:0] d2;
        a1 = rand_bits(32) & ~32'h3;
        d1 = rand_bits(32);
        d2 = rand_bits(32);
        issue_store(a1, d1, tl_pkg::MEM_WORD);
        issue_store(a1 ^ 32'h40, d2, tl_pkg::MEM_HALF);
        drain_and_check(a1, d1, tl_pkg::MEM_WORD);
        drain_and_check(a1 ^ 32'h40, d2, tl_pkg::MEM_HALF);
        expect_empty();
    endtask

    task automatic test_buffer_full;
        logic [31:0] a1;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] d3;
        int          flushes;
        int          cycles;
        a1      = rand_bits(32) & ~32'h3;
        d1      = rand_bits(32);
        d2      = rand_bits(32);
        d3      = rand_bits(32);
        flushes = 0;
        cycles  = 0;
        issue_store(a1, d1, tl_pkg::MEM_WORD);
        issue_store(a1 ^ 32'h4, d2, tl_pkg::MEM_BYTE);
        drive_mem(1'b0, a1 ^ 32'h8, d3, tl_pkg::MEM_WORD);
        @(negedge clk_i);
        assert (hazard_o && !mmu_miss_o) else report_error("third store did not stall");
        while (hazard_o) begin
            step_clock();
            if (sb_flush_o) begin
                assert (flushes == 0 && mem_wr_o && sb_addr_o == a1 && sb_flush_data_o == d1)
                else report_error($sformatf("drained %h during the stall", sb_addr_o));
                flushes++;
            end
            @(negedge clk_i);
            cycles++;
            if (cycles > STALL_LIMIT) abort_run("hazard_o never fell with the buffer full");
        end
        assert (flushes == 1) else report_error($sformatf("%0d drains in the stall", flushes));
        step_clock();  // Third store taken here
        assert (!sb_flush_o && !mem_wr_o) else report_error("drain in the accepting cycle");
        drain_and_check(a1 ^ 32'h4, d2, tl_pkg::MEM_BYTE);
        drain_and_check(a1 ^ 32'h8, d3, tl_pkg::MEM_WORD);
        expect_empty();
    endtask

    // MMU model answering each miss with one fill strobe
    initial begin : mmu_model
        logic [31:0] line_addr;
        logic [31:0] r;
        int          wait_cycles;
        forever begin
            @(negedge clk_i);
            if (mmu_miss_o) begin
                line_addr   = mmu_addr_o;
                r           = rand_bits(2);
                wait_cycles = 2 + int'(r);
                r           = rand_bits(`TL_INDEX_W);
                repeat (wait_cycles) @(posedge clk_i);
                #1;
                mmu_data_rdy_i  = 1'b1;
                mmu_fill_addr_i = line_addr;
                mmu_lru_index_i = r[`TL_INDEX_W-1:0];
                @(posedge clk_i);
                fill_slot[line_addr[`TL_WORD_W-1:`TL_OFFSET_W]] = r[`TL_INDEX_W-1:0];
                fill_count++;
                #1;
                mmu_data_rdy_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        abort_run($sformatf("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        clk_i           = 1'b0;
        rst_n_i         = 1'b0;
        alu_res_i       = '0;
        rf_waddr_i      = '0;
        st_data_i       = '0;
        new_pc_i        = '0;
        mmu_data_rdy_i  = 1'b0;
        mmu_fill_addr_i = '0;
        mmu_lru_index_i = '0;
        lfsr_q          = 16'd86;
        fill_count      = 0;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        test_reset();
        test_pass_through();
        test_load_miss();
        test_forwarding();
        test_drain_order();
        test_buffer_full();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== include/tl_consts.svh ====
`ifndef TL_CONSTS_SVH
`define TL_CONSTS_SVH

// Data and address width
`define TL_WORD_W      32

// Register file write address
`define TL_REG_ADDR_W  5

// Byte offset inside a 16 byte line
`define TL_OFFSET_W    4

// Line tag is every address bit above the offset
`define TL_TAG_W       28

// Fully associative data cache
`define TL_LINES       4
`define TL_INDEX_W     2

// Pending stores waiting for the cache
`define TL_SB_DEPTH    2

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the TL stage testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module tl_tb -f verilog.f \
    && ./obj_dir/Vtl_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qxF "** PASS **" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verilog.f ====
+incdir+include
verilog/tl_pkg.sv
verilog/dcache_tag_array.sv
verilog/store_buffer.sv
verilog/tl_stage.sv
bench/tl_tb.sv

// ==== verilog/dcache_tag_array.sv ====
`include "tl_consts.svh"

module dcache_tag_array (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Lookup
    input  logic                   req_i,
    input  logic [`TL_TAG_W-1:0]   tag_i,
    // Refill from the MMU
    input  logic                   fill_i,
    input  logic [`TL_TAG_W-1:0]   fill_tag_i,
    input  logic [`TL_INDEX_W-1:0] fill_index_i,
    output tl_pkg::tag_resp_t      resp_o
);

    logic [`TL_LINES-1:0]   valid_q;
    logic [`TL_TAG_W-1:0]   tag_q [`TL_LINES];

    logic [`TL_LINES-1:0]   line_hit;
    logic [`TL_INDEX_W-1:0] hit_index;
    logic                   any_hit;

    // Compare every line at once
    always_comb begin
        for (int i = 0; i < `TL_LINES; i++) begin
            line_hit[i] = valid_q[i] && (tag_q[i] == tag_i);
        end
    end

    // A tag lives in one slot only, so the encoder needs no priority
    always_comb begin
        hit_index = '0;
        for (int i = 0; i < `TL_LINES; i++) begin
            if (line_hit[i]) begin
                hit_index = i[`TL_INDEX_W-1:0];
            end
        end
    end

    assign any_hit = |line_hit;

    assign resp_o.hit   = req_i & any_hit;
    assign resp_o.miss  = req_i & ~any_hit;
    assign resp_o.index = hit_index;

    // Valid bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_index_i] <= 1'b1;  // Slot picked by the MMU
        end
    end

    // Tag storage
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[fill_index_i] <= fill_tag_i;
        end
    end

endmodule

// ==== verilog/store_buffer.sv ====
`include "tl_consts.svh"

module store_buffer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // Requests from the stage
    input  logic                  store_i,
    input  logic                  load_i,
    input  logic                  drain_i,
    input  logic [`TL_WORD_W-1:0] addr_i,
    input  logic [`TL_WORD_W-1:0] data_i,
    input  tl_pkg::mem_size_e     size_i,
    output tl_pkg::sb_resp_t      resp_o
);

    // Entry payload
    logic [`TL_WORD_W-1:0]             addr_q [`TL_SB_DEPTH];
    logic [`TL_WORD_W-1:0]             data_q [`TL_SB_DEPTH];
    tl_pkg::mem_size_e                 size_q [`TL_SB_DEPTH];

    // FIFO control
    logic [$clog2(`TL_SB_DEPTH)-1:0]   head_q;   // Oldest entry
    logic [$clog2(`TL_SB_DEPTH)-1:0]   tail_q;   // Next free slot
    logic [$clog2(`TL_SB_DEPTH+1)-1:0] count_q;

    logic [`TL_SB_DEPTH-1:0]           entry_valid;
    logic [`TL_SB_DEPTH-1:0]           word_match;
    logic [$clog2(`TL_SB_DEPTH)-1:0]   match_idx;
    logic [$clog2(`TL_SB_DEPTH)-1:0]   wr_idx;
    logic                              match_any;
    logic                              fwd_hit;
    logic                              hit;
    logic                              full;
    logic                              empty;
    logic                              do_merge;
    logic                              do_push;
    logic                              do_pop;

    assign full  = (count_q == `TL_SB_DEPTH);
    assign empty = (count_q == '0);

    // Entry is live when it sits inside the window head .. head+count-1
    always_comb begin
        logic [$clog2(`TL_SB_DEPTH)-1:0] offset;
        for (int i = 0; i < `TL_SB_DEPTH; i++) begin
            offset         = i[$clog2(`TL_SB_DEPTH)-1:0] - head_q;
            entry_valid[i] = ({1'b0, offset} < count_q);
        end
    end

    // Word address compare, byte offset ignored
    always_comb begin
        for (int i = 0; i < `TL_SB_DEPTH; i++) begin
            word_match[i] = entry_valid[i] &&
                (addr_q[i][`TL_WORD_W-1:$clog2(`TL_WORD_W/8)] ==
                 addr_i[`TL_WORD_W-1:$clog2(`TL_WORD_W/8)]);
        end
    end

    // Coalescing keeps at most one entry per word
    always_comb begin
        match_idx = '0;
        for (int i = 0; i < `TL_SB_DEPTH; i++) begin
            if (word_match[i]) begin
                match_idx = i[$clog2(`TL_SB_DEPTH)-1:0];
            end
        end
    end

    assign match_any = |word_match;

    // Only a full word entry can feed a load
    assign fwd_hit = load_i && match_any && (size_q[match_idx] == tl_pkg::MEM_WORD);
    assign hit     = fwd_hit | (store_i & match_any);

    assign do_merge = store_i & match_any;
    assign do_push  = store_i & ~match_any & ~full;  // Refused while full
    assign do_pop   = drain_i & ~empty;
    assign wr_idx   = do_merge ? match_idx : tail_q;

    assign resp_o.hit         = hit;
    assign resp_o.miss        = (load_i | store_i) & ~hit;
    assign resp_o.full        = full;
    assign resp_o.data_valid  = ~empty;
    assign resp_o.load_data   = data_q[match_idx];
    assign resp_o.oldest_addr = addr_q[head_q];
    assign resp_o.oldest_data = data_q[head_q];
    assign resp_o.oldest_size = size_q[head_q];

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (do_pop) begin
                head_q <= head_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Push and pop cancel
            endcase
        end
    end

    // New entry or merge with the newer data and size
    always_ff @(posedge clk_i) begin
        if (do_merge || do_push) begin
            addr_q[wr_idx] <= addr_i;
            data_q[wr_idx] <= data_i;
            size_q[wr_idx] <= size_i;
        end
    end

endmodule

// ==== verilog/tl_pkg.sv ====
`include "tl_consts.svh"

package tl_pkg;

    // Access size of a load or store
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // Stall state of the tag lookup stage
    typedef enum logic [1:0] {
        TL_IDLE      = 2'd0,
        TL_LOAD_MISS = 2'd1,  // Waiting for the MMU line fill
        TL_SB_FULL   = 2'd2   // Draining to make room for a store
    } tl_state_e;

    // Tag array answer
    typedef struct packed {
        logic                   hit;
        logic                   miss;
        logic [`TL_INDEX_W-1:0] index;  // Slot of the hitting line
    } tag_resp_t;

    // Store buffer answer
    typedef struct packed {
        logic                  hit;
        logic                  miss;
        logic                  full;
        logic                  data_valid;   // Oldest entry present
        logic [`TL_WORD_W-1:0] load_data;    // Forwarded word
        logic [`TL_WORD_W-1:0] oldest_addr;
        logic [`TL_WORD_W-1:0] oldest_data;
        mem_size_e             oldest_size;
    } sb_resp_t;

endpackage

// ==== verilog/tl_stage.sv ====
`include "tl_consts.svh"

module tl_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // Execute side
    input  logic [`TL_WORD_W-1:0]     alu_res_i,
    input  logic                      rf_we_i,
    input  logic [`TL_REG_ADDR_W-1:0] rf_waddr_i,
    input  logic [`TL_WORD_W-1:0]     st_data_i,
    input  logic                      mem_rd_i,
    input  logic                      mem_wr_i,
    input  tl_pkg::mem_size_e         mem_size_i,
    input  logic                      sign_ext_i,
    input  logic                      tkbr_i,
    input  logic [`TL_WORD_W-1:0]     new_pc_i,
    // Memory side
    output logic [`TL_WORD_W-1:0]     alu_res_o,
    output logic                      rf_we_o,
    output logic [`TL_REG_ADDR_W-1:0] rf_waddr_o,
    output logic                      mem_rd_o,
    output logic                      mem_wr_o,
    output tl_pkg::mem_size_e         mem_size_o,
    output logic                      sign_ext_o,
    output logic                      tkbr_o,
    output logic [`TL_WORD_W-1:0]     new_pc_o,
    output logic [`TL_INDEX_W-1:0]    addr_index_o,
    output logic                      sb_hit_o,
    output logic [`TL_WORD_W-1:0]     sb_load_data_o,
    output logic                      sb_flush_o,
    output logic [`TL_WORD_W-1:0]     sb_addr_o,
    output logic [`TL_WORD_W-1:0]     sb_flush_data_o,
    output tl_pkg::mem_size_e         sb_flush_size_o,
    // MMU side
    input  logic                      mmu_data_rdy_i,
    input  logic [`TL_WORD_W-1:0]     mmu_fill_addr_i,
    input  logic [`TL_INDEX_W-1:0]    mmu_lru_index_i,
    output logic                      mmu_miss_o,
    output logic [`TL_WORD_W-1:0]     mmu_addr_o,
    // Pipeline stall
    output logic                      hazard_o
);

    tl_pkg::tl_state_e state_q;
    tl_pkg::tl_state_e state_d;
    tl_pkg::tag_resp_t tag_resp;
    tl_pkg::sb_resp_t  sb_resp;

    logic idle;
    logic ld_req;
    logic st_req;
    logic load_miss;
    logic store_full;
    logic drain;
    logic flush;
    logic hazard;

    assign idle   = (state_q == tl_pkg::TL_IDLE);
    assign ld_req = idle & mem_rd_i;  // Lookups only start from idle
    assign st_req = idle & mem_wr_i;

    dcache_tag_array u_tag_array (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (ld_req),
        .tag_i        (alu_res_i[`TL_WORD_W-1:`TL_OFFSET_W]),
        .fill_i       (mmu_data_rdy_i),
        .fill_tag_i   (mmu_fill_addr_i[`TL_WORD_W-1:`TL_OFFSET_W]),
        .fill_index_i (mmu_lru_index_i),
        .resp_o       (tag_resp)
    );

    store_buffer u_store_buffer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .store_i (st_req),
        .load_i  (ld_req),
        .drain_i (drain),
        .addr_i  (alu_res_i),
        .data_i  (st_data_i),
        .size_i  (mem_size_i),
        .resp_o  (sb_resp)
    );

    // Load served by neither the cache nor the store buffer
    assign load_miss = tag_resp.miss & sb_resp.miss;

    // Store that can neither merge nor find a free entry
    assign store_full = st_req & sb_resp.full & ~sb_resp.hit;

    // Drain when forced by a full buffer or when the slot is free
    assign drain = (state_q == tl_pkg::TL_SB_FULL) || (idle && !mem_rd_i && !mem_wr_i);
    assign flush = drain & sb_resp.data_valid;

    assign hazard   = load_miss | store_full | ~idle;
    assign hazard_o = hazard;

    // Request stays up until the fill strobe
    assign mmu_miss_o = load_miss ||
                        ((state_q == tl_pkg::TL_LOAD_MISS) && !mmu_data_rdy_i);
    assign mmu_addr_o = {alu_res_i[`TL_WORD_W-1:`TL_OFFSET_W], {`TL_OFFSET_W{1'b0}}};

    always_comb begin
        state_d = state_q;
        case (state_q)
            tl_pkg::TL_IDLE: begin
                if (load_miss) begin
                    state_d = tl_pkg::TL_LOAD_MISS;
                end else if (store_full) begin
                    state_d = tl_pkg::TL_SB_FULL;
                end
            end
            tl_pkg::TL_LOAD_MISS: begin
                if (mmu_data_rdy_i) begin
                    state_d = tl_pkg::TL_IDLE;  // Held load hits next cycle
                end
            end
            tl_pkg::TL_SB_FULL: begin
                state_d = tl_pkg::TL_IDLE;  // One drain frees an entry
            end
            default: begin
                state_d = tl_pkg::TL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= tl_pkg::TL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Registers toward the memory stage
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_res_o       <= '0;
            rf_we_o         <= 1'b0;
            rf_waddr_o      <= '0;
            mem_rd_o        <= 1'b0;
            mem_wr_o        <= 1'b0;
            mem_size_o      <= tl_pkg::MEM_WORD;
            sign_ext_o      <= 1'b0;
            tkbr_o          <= 1'b0;
            new_pc_o        <= '0;
            addr_index_o    <= '0;
            sb_hit_o        <= 1'b0;
            sb_load_data_o  <= '0;
            sb_flush_o      <= 1'b0;
            sb_addr_o       <= '0;
            sb_flush_data_o <= '0;
            sb_flush_size_o <= tl_pkg::MEM_WORD;
        end else begin
            alu_res_o    <= alu_res_i;
            rf_waddr_o   <= rf_waddr_i;
            mem_size_o   <= mem_size_i;
            sign_ext_o   <= sign_ext_i;
            new_pc_o     <= new_pc_i;
            addr_index_o <= tag_resp.index;
            // A stalled operation leaves a bubble
            rf_we_o      <= rf_we_i & ~hazard;
            tkbr_o       <= tkbr_i & ~hazard;
            mem_rd_o     <= ~hazard & tag_resp.hit & ~sb_resp.hit;
            sb_hit_o     <= ~hazard & ld_req & sb_resp.hit;  // Forwarded load
            sb_load_data_o <= sb_resp.load_data;

            // Stores only reach memory through a drain
            mem_wr_o   <= flush;
            sb_flush_o <= flush;
            if (flush) begin
                sb_addr_o       <= sb_resp.oldest_addr;
                sb_flush_data_o <= sb_resp.oldest_data;
                sb_flush_size_o <= sb_resp.oldest_size;
            end
        end
    end

endmodule
